/* wrr_rank_defines.svh */
`ifndef WRR_RANK_DEFINES_SVH
`define WRR_RANK_DEFINES_SVH

// Flow table geometry
`define WRR_PORTS        5
`define WRR_CLASSES      32
`define WRR_FLOWS        160

// Field widths
`define WRR_CLASS_W      5
`define WRR_PORT_W       3
`define WRR_PORT_BYTE_W  8     // One-hot port byte in the input tuple
`define WRR_ROUND_W      11
`define WRR_OVF_W        2
`define WRR_WEIGHT_W     8
`define WRR_WORD_W       32    // Rank output and dequeue word
`define WRR_INFO_W       12    // PIFO info, always zero here

`define WRR_MAX_ROUND    2047

// One-hot port byte codes, anything else is the CPU port
`define WRR_PORT0_CODE   8'h01
`define WRR_PORT1_CODE   8'h04
`define WRR_PORT2_CODE   8'h10
`define WRR_PORT3_CODE   8'h40

`endif

/* wrr_rank_pkg.sv */
`include "wrr_rank_defines.svh"

package wrr_rank_pkg;

   // Port id above class
   typedef logic [`WRR_PORT_W+`WRR_CLASS_W-1:0] flow_idx_t;

   // Rank field of the output word, the spare bit sits just above the PIFO info
   typedef struct packed
   {
      logic [`WRR_OVF_W-1:0]   ovf;
      logic [`WRR_ROUND_W-1:0] round;
      logic [`WRR_CLASS_W-1:0] cls;
      logic                    pad;
   } rank_t;

   // Per-flow state, also the readback layout
   typedef struct packed
   {
      logic [`WRR_OVF_W-1:0]    ovf;
      logic [`WRR_ROUND_W-1:0]  round;
      logic [`WRR_WEIGHT_W-1:0] cfg_weight;
      logic [`WRR_WEIGHT_W-1:0] weight;
   } flow_state_t;

   // Last dequeued position of one port
   typedef struct packed
   {
      logic                    valid;
      logic [`WRR_OVF_W-1:0]   ovf;
      logic [`WRR_ROUND_W-1:0] round;
   } dq_info_t;

endpackage

/* wrr_cmd_if.sv */
`include "wrr_rank_defines.svh"

// Decoded packet and dequeue info, valid in the current cycle only
interface wrr_cmd_if;

   logic                      pkt_valid;
   wrr_rank_pkg::flow_idx_t   pkt_flow;
   logic [`WRR_CLASS_W-1:0]   pkt_class;
   wrr_rank_pkg::dq_info_t    dq [`WRR_PORTS];   // One entry per output port

   modport decode
   (
      output pkt_valid,
      output pkt_flow,
      output pkt_class,
      output dq
   );

   modport execute
   (
      input pkt_valid,
      input pkt_flow,
      input pkt_class,
      input dq
   );

endinterface

/* wrr_decode.sv */
`include "wrr_rank_defines.svh"

module wrr_decode
(
   input  logic                                   pkt_valid_i,
   input  logic [`WRR_PORT_BYTE_W+`WRR_CLASS_W-1:0] pkt_data_i,
   input  logic [`WRR_WORD_W-1:0]                 dq_info0_i,
   input  logic [`WRR_WORD_W-1:0]                 dq_info1_i,
   input  logic [`WRR_WORD_W-1:0]                 dq_info2_i,
   input  logic [`WRR_WORD_W-1:0]                 dq_info3_i,
   input  logic [`WRR_WORD_W-1:0]                 dq_info4_i,
   wrr_cmd_if.decode                              cmd
);

   // Dequeue word layout, valid on top then overflow and round
   localparam int VALID_BIT = `WRR_WORD_W - 1;
   localparam int OVF_HI    = VALID_BIT - 1;
   localparam int OVF_LO    = OVF_HI - `WRR_OVF_W + 1;
   localparam int ROUND_HI  = OVF_LO - 1;
   localparam int ROUND_LO  = ROUND_HI - `WRR_ROUND_W + 1;

   logic [`WRR_PORT_BYTE_W-1:0] port_byte;
   logic [`WRR_CLASS_W-1:0]     pkt_class;
   logic [`WRR_PORT_W-1:0]      port_id;
   logic [`WRR_WORD_W-1:0]      dq_word [`WRR_PORTS];

   assign port_byte = pkt_data_i[`WRR_PORT_BYTE_W+`WRR_CLASS_W-1:`WRR_CLASS_W];
   assign pkt_class = pkt_data_i[`WRR_CLASS_W-1:0];

   assign dq_word[0] = dq_info0_i;
   assign dq_word[1] = dq_info1_i;
   assign dq_word[2] = dq_info2_i;
   assign dq_word[3] = dq_info3_i;
   assign dq_word[4] = dq_info4_i;

   // One-hot port byte to port id
   always_comb
   begin
      case (port_byte)
         `WRR_PORT0_CODE: port_id = 3'd0;
         `WRR_PORT1_CODE: port_id = 3'd1;
         `WRR_PORT2_CODE: port_id = 3'd2;
         `WRR_PORT3_CODE: port_id = 3'd3;
         default:         port_id = 3'd4;   // CPU port
      endcase
   end

   assign cmd.pkt_valid = pkt_valid_i;
   assign cmd.pkt_flow  = {port_id, pkt_class};
   assign cmd.pkt_class = pkt_class;

   // Unpack the dequeue words, the low bits carry class and info and are not needed
   always_comb
   begin
      for (int p = 0; p < `WRR_PORTS; p++)
      begin
         cmd.dq[p].valid = dq_word[p][VALID_BIT];
         cmd.dq[p].ovf   = dq_word[p][OVF_HI:OVF_LO];
         cmd.dq[p].round = dq_word[p][ROUND_HI:ROUND_LO];
      end
   end

endmodule

/* wrr_execute.sv */
`include "wrr_rank_defines.svh"

module wrr_execute
(
   input  logic                      clk_control,
   input  logic                      clk_control_rst_low,
   wrr_cmd_if.execute                cmd,
   input  logic                      cpu_wr_valid_i,
   input  wrr_rank_pkg::flow_idx_t   cpu_wr_index_i,
   input  logic [`WRR_WEIGHT_W-1:0]  cpu_wr_data_i,
   input  logic                      cpu_rd_valid_i,
   input  wrr_rank_pkg::flow_idx_t   cpu_rd_index_i,
   output logic                      rank_valid_o,
   output wrr_rank_pkg::rank_t       rank_o,
   output logic                      rd_valid_o,
   output wrr_rank_pkg::flow_idx_t   rd_index_o,
   output wrr_rank_pkg::flow_state_t rd_state_o
);

   // Idle flow, configured weight of one
   localparam wrr_rank_pkg::flow_state_t FLOW_RESET = '{
      ovf:        '0,
      round:      '0,
      cfg_weight: `WRR_WEIGHT_W'(1),
      weight:     '0
   };

   wrr_rank_pkg::flow_state_t table_q [`WRR_FLOWS];
   wrr_rank_pkg::flow_state_t table_d [`WRR_FLOWS];

   // Next state of every flow, resync first, then the WRR step, then CPU writes
   always_comb
   begin
      wrr_rank_pkg::flow_state_t st;
      wrr_rank_pkg::dq_info_t    dq;

      for (int f = 0; f < `WRR_FLOWS; f++)
      begin
         st = table_q[f];
         dq = cmd.dq[f / `WRR_CLASSES];   // Dequeue info of this flow's port

         if (dq.valid)
         begin
            if ((dq.ovf > st.ovf) ||
                (dq.ovf == '0 && st.ovf == {`WRR_OVF_W{1'b1}}))   // Dequeue side wrapped
            begin
               st.ovf    = dq.ovf;
               st.round  = dq.round;
               st.weight = '0;
            end
            else if ((dq.ovf == st.ovf) && (dq.round > st.round))
            begin
               st.round  = dq.round;
               st.weight = '0;
            end
         end

         // WRR step on the resynced values
         if (cmd.pkt_valid && (cmd.pkt_flow == f))
         begin
            if (st.weight < st.cfg_weight)
            begin
               st.weight = st.weight + 1'b1;
            end
            else if (st.round < `WRR_MAX_ROUND)
            begin
               st.weight = `WRR_WEIGHT_W'(1);
               st.round  = st.round + 1'b1;
            end
            else
            begin
               st.weight = `WRR_WEIGHT_W'(1);
               st.round  = `WRR_ROUND_W'(1);
               st.ovf    = st.ovf + 1'b1;   // Wraps modulo 4
            end
         end

         // Out-of-range write index never matches
         if (cpu_wr_valid_i && (cpu_wr_index_i == f))
         begin
            st.cfg_weight = cpu_wr_data_i;
         end

         table_d[f] = st;
      end
   end

   always_ff @(posedge clk_control)
   begin
      if (clk_control_rst_low)
      begin
         for (int f = 0; f < `WRR_FLOWS; f++)
         begin
            table_q[f] <= FLOW_RESET;
         end
      end
      else
      begin
         table_q <= table_d;
      end
   end

   // Rank from the post-step state of the packet's flow
   always_comb
   begin
      rank_o.ovf   = table_d[cmd.pkt_flow].ovf;
      rank_o.round = table_d[cmd.pkt_flow].round;
      rank_o.cls   = cmd.pkt_class;
      rank_o.pad   = 1'b0;
   end

   assign rank_valid_o = cmd.pkt_valid;

   // Readback sees the state from before the edge
   assign rd_valid_o = cpu_rd_valid_i;
   assign rd_index_o = cpu_rd_index_i;
   assign rd_state_o = (cpu_rd_index_i < `WRR_FLOWS) ? table_q[cpu_rd_index_i] : '0;

endmodule

/* wrr_result.sv */
`include "wrr_rank_defines.svh"

module wrr_result
(
   input  logic                      clk_control,
   input  logic                      clk_control_rst_low,
   input  logic                      rank_valid_i,
   input  wrr_rank_pkg::rank_t       rank_i,
   input  logic                      rd_valid_i,
   input  wrr_rank_pkg::flow_idx_t   rd_index_i,
   input  wrr_rank_pkg::flow_state_t rd_state_i,
   output logic                      rank_valid_o,
   output logic [`WRR_WORD_W-1:0]    rank_data_o,
   output logic                      cpu_rd_valid_o,
   output wrr_rank_pkg::flow_idx_t   cpu_rd_index_o,
   output logic [`WRR_WORD_W-1:0]    cpu_rd_data_o
);

   localparam int RD_PAD_W = `WRR_WORD_W - $bits(wrr_rank_pkg::flow_state_t);

   always_ff @(posedge clk_control)
   begin
      if (clk_control_rst_low)
      begin
         rank_valid_o   <= 1'b0;
         rank_data_o    <= '0;
         cpu_rd_valid_o <= 1'b0;
         cpu_rd_index_o <= '0;
         cpu_rd_data_o  <= '0;
      end
      else
      begin
         rank_valid_o   <= rank_valid_i;
         cpu_rd_valid_o <= rd_valid_i;

         // Valid bit, rank, then the unused PIFO info
         if (rank_valid_i)
            rank_data_o <= {1'b1, rank_i, {`WRR_INFO_W{1'b0}}};
         else
            rank_data_o <= '0;

         if (rd_valid_i)
         begin
            cpu_rd_index_o <= rd_index_i;
            cpu_rd_data_o  <= {{RD_PAD_W{1'b0}}, rd_state_i};
         end
         else
         begin
            cpu_rd_index_o <= '0;
            cpu_rd_data_o  <= '0;
         end
      end
   end

endmodule

/* wrr_rank_calc.sv */
`include "wrr_rank_defines.svh"

module wrr_rank_calc
(
   input  logic                                   clk_control,
   input  logic                                   clk_control_rst_low,
   input  logic                                   pkt_valid_i,
   input  logic [`WRR_PORT_BYTE_W+`WRR_CLASS_W-1:0] pkt_data_i,
   input  logic [`WRR_WORD_W-1:0]                 dq_info0_i,
   input  logic [`WRR_WORD_W-1:0]                 dq_info1_i,
   input  logic [`WRR_WORD_W-1:0]                 dq_info2_i,
   input  logic [`WRR_WORD_W-1:0]                 dq_info3_i,
   input  logic [`WRR_WORD_W-1:0]                 dq_info4_i,
   input  logic                                   cpu_wr_valid_i,
   input  logic [`WRR_PORT_W+`WRR_CLASS_W-1:0]    cpu_wr_index_i,
   input  logic [`WRR_WEIGHT_W-1:0]               cpu_wr_data_i,
   input  logic                                   cpu_rd_valid_i,
   input  logic [`WRR_PORT_W+`WRR_CLASS_W-1:0]    cpu_rd_index_i,
   output logic                                   rank_valid_o,
   output logic [`WRR_WORD_W-1:0]                 rank_data_o,
   output logic                                   cpu_rd_valid_o,
   output logic [`WRR_PORT_W+`WRR_CLASS_W-1:0]    cpu_rd_index_o,
   output logic [`WRR_WORD_W-1:0]                 cpu_rd_data_o
);

   logic                      rank_valid;
   wrr_rank_pkg::rank_t       rank;
   logic                      rd_valid;
   wrr_rank_pkg::flow_idx_t   rd_index;
   wrr_rank_pkg::flow_state_t rd_state;

   wrr_cmd_if i_cmd_if ();

   wrr_decode i_wrr_decode
   (
      .pkt_valid_i (pkt_valid_i),
      .pkt_data_i  (pkt_data_i),
      .dq_info0_i  (dq_info0_i),
      .dq_info1_i  (dq_info1_i),
      .dq_info2_i  (dq_info2_i),
      .dq_info3_i  (dq_info3_i),
      .dq_info4_i  (dq_info4_i),
      .cmd         (i_cmd_if.decode)
   );

   wrr_execute i_wrr_execute
   (
      .clk_control         (clk_control),
      .clk_control_rst_low (clk_control_rst_low),
      .cmd                 (i_cmd_if.execute),
      .cpu_wr_valid_i      (cpu_wr_valid_i),
      .cpu_wr_index_i      (cpu_wr_index_i),
      .cpu_wr_data_i       (cpu_wr_data_i),
      .cpu_rd_valid_i      (cpu_rd_valid_i),
      .cpu_rd_index_i      (cpu_rd_index_i),
      .rank_valid_o        (rank_valid),
      .rank_o              (rank),
      .rd_valid_o          (rd_valid),
      .rd_index_o          (rd_index),
      .rd_state_o          (rd_state)
   );

   wrr_result i_wrr_result
   (
      .clk_control         (clk_control),
      .clk_control_rst_low (clk_control_rst_low),
      .rank_valid_i        (rank_valid),
      .rank_i              (rank),
      .rd_valid_i          (rd_valid),
      .rd_index_i          (rd_index),
      .rd_state_i          (rd_state),
      .rank_valid_o        (rank_valid_o),
      .rank_data_o         (rank_data_o),
      .cpu_rd_valid_o      (cpu_rd_valid_o),
      .cpu_rd_index_o      (cpu_rd_index_o),
      .cpu_rd_data_o       (cpu_rd_data_o)
   );

endmodule

/* wrr_rank_calc_sva.sv */
`include "wrr_rank_defines.svh"

module wrr_rank_calc_sva
(
   input logic                   clk_control,
   input logic                   clk_control_rst_low,
   input logic                   pkt_valid_i,
   input logic                   cpu_rd_valid_i,
   input logic                   rank_valid_o,
   input logic [`WRR_WORD_W-1:0] rank_data_o,
   input logic                   cpu_rd_valid_o
);
   timeunit 1ns;
   timeprecision 100ps;

   int fail_count = 0;   // Read by the testbench at the end of the run

   // One cycle from packet strobe to rank strobe
   rank_valid_follows: assert property (@(posedge clk_control) disable iff (clk_control_rst_low)
      1'b1 |=> (rank_valid_o == $past(pkt_valid_i)))
   else
   begin
      $error("rank_valid_o does not follow pkt_valid_i by one cycle");
      fail_count++;
   end

   rd_valid_follows: assert property (@(posedge clk_control) disable iff (clk_control_rst_low)
      1'b1 |=> (cpu_rd_valid_o == $past(cpu_rd_valid_i)))
   else
   begin
      $error("cpu_rd_valid_o does not follow cpu_rd_valid_i by one cycle");
      fail_count++;
   end

   // PIFO info field is never filled in
   info_zero: assert property (@(posedge clk_control) disable iff (clk_control_rst_low)
      rank_data_o[`WRR_INFO_W-1:0] == '0)
   else
   begin
      $error("PIFO info bits of rank_data_o are not zero");
      fail_count++;
   end

   reset_quiet: assert property (@(posedge clk_control)
      clk_control_rst_low |=> (!rank_valid_o && !cpu_rd_valid_o))
   else
   begin
      $error("A valid output is high during reset");
      fail_count++;
   end

endmodule

bind wrr_rank_calc wrr_rank_calc_sva i_wrr_rank_calc_sva
(
   .clk_control         (clk_control),
   .clk_control_rst_low (clk_control_rst_low),
   .pkt_valid_i         (pkt_valid_i),
   .cpu_rd_valid_i      (cpu_rd_valid_i),
   .rank_valid_o        (rank_valid_o),
   .rank_data_o         (rank_data_o),
   .cpu_rd_valid_o      (cpu_rd_valid_o)
);

/* tb_wrr_rank_calc.sv */
`include "wrr_rank_defines.svh"

module tb_wrr_rank_calc;
   timeunit 1ns;
   timeprecision 100ps;

   logic                                    clk_control = 1'b0;
   logic                                    clk_control_rst_low;
   logic                                    pkt_valid_i;
   logic [`WRR_PORT_BYTE_W+`WRR_CLASS_W-1:0] pkt_data_i;
   logic [`WRR_WORD_W-1:0]                  dq_info [`WRR_PORTS];
   logic                                    cpu_wr_valid_i;
   logic [7:0]                              cpu_wr_index_i;
   logic [`WRR_WEIGHT_W-1:0]                cpu_wr_data_i;
   logic                                    cpu_rd_valid_i;
   logic [7:0]                              cpu_rd_index_i;
   logic                                    rank_valid_o;
   logic [`WRR_WORD_W-1:0]                  rank_data_o;
   logic                                    cpu_rd_valid_o;
   logic [7:0]                              cpu_rd_index_o;
   logic [`WRR_WORD_W-1:0]                  cpu_rd_data_o;

   int error_count       = 0;
   int check_count       = 0;
   int test_count        = 0;
   int failed_tests      = 0;
   int test_start_errors = 0;
   int cycle_count       = 0;
   int cycle_limit       = 100;   // Grows with the stim file length

   always #2 clk_control = ~clk_control;   // 4 ns period

   always @(posedge clk_control)
   begin
      cycle_count++;
      if (cycle_count > cycle_limit)
      begin
         $display("Timeout: run did not finish within %0d cycles", cycle_limit);
         $display("TEST FAIL");
         $finish;
      end
   end

   wrr_rank_calc i_wrr_rank_calc
   (
      .clk_control         (clk_control),
      .clk_control_rst_low (clk_control_rst_low),
      .pkt_valid_i         (pkt_valid_i),
      .pkt_data_i          (pkt_data_i),
      .dq_info0_i          (dq_info[0]),
      .dq_info1_i          (dq_info[1]),
      .dq_info2_i          (dq_info[2]),
      .dq_info3_i          (dq_info[3]),
      .dq_info4_i          (dq_info[4]),
      .cpu_wr_valid_i      (cpu_wr_valid_i),
      .cpu_wr_index_i      (cpu_wr_index_i),
      .cpu_wr_data_i       (cpu_wr_data_i),
      .cpu_rd_valid_i      (cpu_rd_valid_i),
      .cpu_rd_index_i      (cpu_rd_index_i),
      .rank_valid_o        (rank_valid_o),
      .rank_data_o         (rank_data_o),
      .cpu_rd_valid_o      (cpu_rd_valid_o),
      .cpu_rd_index_o      (cpu_rd_index_o),
      .cpu_rd_data_o       (cpu_rd_data_o)
   );

   task automatic check_value(input string sig_name, input logic [31:0] actual,
                              input logic [31:0] expected);
      check_count++;
      if (actual !== expected)
      begin
         error_count++;
         $display("CHECK FAILED at %0d ns: %s is %h, expected %h",
                  $time, sig_name, actual, expected);
      end
   endtask

   // Called on a falling edge, returns on the falling edge one cycle later
   task automatic next_cycle();
      @(posedge clk_control);
      @(negedge clk_control);
   endtask

   task automatic apply_reset();
      clk_control_rst_low = 1'b1;
      pkt_valid_i         = 1'b1;   // Strobes high while in reset
      pkt_data_i          = '0;
      cpu_wr_valid_i      = 1'b0;
      cpu_wr_index_i      = '0;
      cpu_wr_data_i       = '0;
      cpu_rd_valid_i      = 1'b1;
      cpu_rd_index_i      = '0;
      for (int p = 0; p < `WRR_PORTS; p++)
         dq_info[p] = '0;
      for (int i = 0; i < 10; i++)
      begin
         @(negedge clk_control);
         check_value("rank_valid_o", rank_valid_o, 32'd0);
         check_value("cpu_rd_valid_o", cpu_rd_valid_o, 32'd0);
         if (i == 8)
         begin
            pkt_valid_i    = 1'b0;   // Quiet for the last reset cycle
            cpu_rd_valid_i = 1'b0;
         end
      end
      clk_control_rst_low = 1'b0;
   endtask

   task automatic send_packet(input logic [31:0] port_byte, input logic [31:0] cls,
                              input logic [31:0] expected);
      pkt_valid_i = 1'b1;
      pkt_data_i  = {port_byte[7:0], cls[`WRR_CLASS_W-1:0]};
      next_cycle();
      pkt_valid_i = 1'b0;
      check_value("rank_valid_o", rank_valid_o, 32'd1);
      check_value("rank_data_o", rank_data_o, expected);
   endtask

   task automatic write_weight(input logic [31:0] index, input logic [31:0] weight);
      cpu_wr_valid_i = 1'b1;
      cpu_wr_index_i = index[7:0];
      cpu_wr_data_i  = weight[`WRR_WEIGHT_W-1:0];
      next_cycle();
      cpu_wr_valid_i = 1'b0;
      check_value("cpu_rd_valid_o", cpu_rd_valid_o, 32'd0);   // Writes are silent
      // Idle output words hold zeros
      check_value("cpu_rd_index_o", cpu_rd_index_o, 32'd0);
      check_value("cpu_rd_data_o", cpu_rd_data_o, 32'd0);
      check_value("rank_data_o", rank_data_o, 32'd0);
   endtask

   task automatic read_flow(input logic [31:0] index, input logic [31:0] expected);
      cpu_rd_valid_i = 1'b1;
      cpu_rd_index_i = index[7:0];
      next_cycle();
      cpu_rd_valid_i = 1'b0;
      check_value("cpu_rd_valid_o", cpu_rd_valid_o, 32'd1);
      check_value("cpu_rd_index_o", cpu_rd_index_o, index);
      check_value("cpu_rd_data_o", cpu_rd_data_o, expected);
   endtask

   // Word layout is valid, overflow, round, then unused low bits
   task automatic drive_dequeue(input logic [31:0] port, input logic [31:0] valid,
                                input logic [31:0] ovf, input logic [31:0] round);
      dq_info[port] = {valid[0], ovf[1:0], round[10:0], 18'h0};
      next_cycle();
      for (int p = 0; p < `WRR_PORTS; p++)
         dq_info[p] = '0;
   endtask

   task automatic finish_test(input string name);
      int errs;
      errs = error_count - test_start_errors;
      test_count++;
      if (errs != 0)
         failed_tests++;
      $display("%0d ns test %s: %s, %0d check errors", $time, name,
               (errs == 0) ? "passed" : "failed", errs);
      test_start_errors = error_count;
   endtask

   initial
   begin
      string       text;
      string       cmd;
      string       name;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      logic [31:0] d;
      int          fd;
      int          line_count;
      int          total;

      line_count = 0;
      fd = $fopen("wrr_stim.txt", "r");
      if (fd == 0)
      begin
         $display("Cannot open the stimulus file wrr_stim.txt");
         $display("TEST FAIL");
         $finish;
      end
      else
      begin
         while ($fgets(text, fd) != 0)
            line_count++;
         $fclose(fd);
         cycle_limit = 100 + 4 * line_count;

         apply_reset();
         fd = $fopen("wrr_stim.txt", "r");
         while ($fgets(text, fd) != 0)
         begin
            if (text.len() > 1 && text[0] != "#")
            begin
               void'($sscanf(text, "%s", cmd));
               case (cmd)
                  "PKT":
                  begin
                     void'($sscanf(text, "%s %h %h %h", cmd, a, b, c));
                     send_packet(a, b, c);
                  end
                  "WR":
                  begin
                     void'($sscanf(text, "%s %h %h", cmd, a, b));
                     write_weight(a, b);
                  end
                  "RD":
                  begin
                     void'($sscanf(text, "%s %h %h", cmd, a, b));
                     read_flow(a, b);
                  end
                  "DQ":
                  begin
                     void'($sscanf(text, "%s %h %h %h %h", cmd, a, b, c, d));
                     drive_dequeue(a, b, c, d);
                  end
                  "END":
                  begin
                     void'($sscanf(text, "%s %s", cmd, name));
                     finish_test(name);
                  end
                  default:
                  begin
                     error_count++;
                     $display("Unknown command in stimulus line: %s", text);
                  end
               endcase
            end
         end
         $fclose(fd);

         next_cycle();   // Let the last assertions settle
         total = error_count + i_wrr_rank_calc.i_wrr_rank_calc_sva.fail_count;
         $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d assertion fails",
                  test_count, failed_tests, check_count, error_count,
                  i_wrr_rank_calc.i_wrr_rank_calc_sva.fail_count);
         if (total == 0)
            $display("TEST PASS");
         else
            $display("TEST FAIL");
         $finish;
      end
   end

endmodule

/* sources.f */
+incdir+.
wrr_rank_pkg.sv
wrr_cmd_if.sv
wrr_decode.sv
wrr_execute.sv
wrr_result.sv
wrr_rank_calc.sv
wrr_rank_calc_sva.sv
tb_wrr_rank_calc.sv

/* wrr_stim.txt */
# PKT port_byte class rank_word | RD index readback_word | WR index weight
# DQ port valid ovf round | END test_name   (numbers in hex)
RD 00 00000100
RD 25 00000100
RD 9f 00000100
END reset_state
WR 23 03
PKT 04 03 80006000
PKT 04 03 80006000
PKT 04 03 80006000
PKT 04 03 80046000
PKT 04 03 80046000
PKT 04 03 80046000
PKT 04 03 80086000
RD 23 00020301
END wrr_counting
PKT 01 07 8000e000
PKT 04 07 8000e000
PKT 10 07 8000e000
PKT 40 07 8000e000
PKT 80 07 8000e000
RD 07 00000101
RD 27 00000101
RD 47 00000101
RD 67 00000101
RD 87 00000101
RD 06 00000100
RD 23 00020301
END port_decode
DQ 2 1 0 005
RD 47 00050100
RD 40 00050100
PKT 10 07 8014e000
DQ 2 1 0 003
RD 47 00050101
DQ 2 0 0 009
RD 47 00050101
RD 07 00000101
END dq_resync
DQ 3 1 0 7ff
RD 62 07ff0100
PKT 40 02 9ffc4000
PKT 40 02 a0044000
RD 62 08010101
DQ 3 1 2 004
RD 62 10040100
DQ 3 1 3 006
DQ 3 1 0 002
RD 62 00020100
END round_overflow
WR c8 05
RD c8 00000000
RD 00 00000100
RD 9f 00000100
END out_of_range
